/* src/cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

    // ============================================================
    // Widths and flag positions
    // ============================================================
    parameter int DATA_WIDTH        = 8;
    parameter int OPCODE_WIDTH      = 8;
    parameter int NUM_STEPS_DEFAULT = 8;  // Microstep slots per opcode

    parameter int FLAG_ZERO  = 0;
    parameter int FLAG_CARRY = 1;
    parameter int FLAG_NEG   = 2;

    // ============================================================
    // Instruction set
    // ============================================================
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP    = 8'h00,
        HLT    = 8'h01,
        JMP    = 8'h10,
        JZ     = 8'h11,
        JNZ    = 8'h12,
        JC     = 8'h13,
        JNC    = 8'h14,
        JN     = 8'h15,
        JNN    = 8'h16,
        ADD_B  = 8'h20,
        SUB_B  = 8'h21,
        CMP_B  = 8'h22,
        INR_A  = 8'h23,
        ANI    = 8'h24,
        RAL    = 8'h25,
        MOV_AB = 8'h30,
        LDI_A  = 8'h31,
        LDA    = 8'h32,
        STA    = 8'h33,
        SEC    = 8'h40,
        CLC    = 8'h41
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_UNDEFINED = 4'h0,
        ALU_ADD       = 4'h1,
        ALU_SUB       = 4'h2,
        ALU_INR       = 4'h3,
        ALU_AND       = 4'h4,
        ALU_ROL       = 4'h5
    } alu_op_t;

    typedef enum logic [3:0] {
        S_RESET,
        S_VEC_ADDR,        // MAR from vector address
        S_VEC_READ,
        S_VEC_LATCH,       // PC byte from RAM
        S_LATCH_ADDR,      // MAR from PC
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } fsm_state_t;

    // ============================================================
    // Control word
    // ============================================================
    typedef struct packed {
        // Load strobes
        logic    load_mar_vec_low;
        logic    load_mar_vec_high;
        logic    load_mar_pc;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        logic    load_a;
        logic    load_b;
        logic    load_status;
        logic    load_ram;
        // Bus drivers
        logic    oe_ram;
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    oe_a;
        logic    oe_alu;
        // Datapath controls
        logic    pc_enable;
        alu_op_t alu_op;
        logic    alu_src2_temp1;  // Second ALU operand from temp_1, else B
        logic    load_sets_zn;
        logic    set_carry_flag;
        logic    clear_carry_flag;
        // Read by the sequencer only
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_not_carry;
        logic    check_negative;
        logic    check_not_negative;
        logic    halt;
        logic    last_step;
    } control_word_t;

endpackage

`default_nettype wire

/* src/seq_state_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface seq_state_if #(
    parameter int NUM_STEPS = cpu_ctrl_pkg::NUM_STEPS_DEFAULT
);
    localparam int STEP_W = $clog2(NUM_STEPS);

    // Registered values
    cpu_ctrl_pkg::fsm_state_t state;
    logic [STEP_W-1:0]        microstep;
    logic [1:0]               byte_count;
    logic                     vec_byte;     // 0 low, 1 high vector byte
    cpu_ctrl_pkg::alu_op_t    alu_op;

    // Next values from the state logic
    cpu_ctrl_pkg::fsm_state_t state_next;
    logic [STEP_W-1:0]        microstep_next;
    logic [1:0]               byte_count_next;
    logic                     vec_byte_next;
    cpu_ctrl_pkg::alu_op_t    alu_op_next;
    logic                     latch_alu_op; // Enable for the ALU-op register

    modport regs (
        input  state_next, microstep_next, byte_count_next, vec_byte_next,
               alu_op_next, latch_alu_op,
        output state, microstep, byte_count, vec_byte, alu_op
    );

    modport logic_side (
        input  state, microstep, byte_count, vec_byte, alu_op,
        output state_next, microstep_next, byte_count_next, vec_byte_next,
               alu_op_next, latch_alu_op
    );

endinterface

`default_nettype wire

/* src/sequencer_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module sequencer_regs #(
    parameter int NUM_STEPS = cpu_ctrl_pkg::NUM_STEPS_DEFAULT
) (
    input  wire logic    clk,
    input  wire logic    reset,
    seq_state_if.regs    st
);
    localparam int STEP_W = $clog2(NUM_STEPS);

    // ============================================================
    // Sequencer state
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            st.state      <= cpu_ctrl_pkg::S_RESET;
            st.microstep  <= {STEP_W{1'b0}};
            st.byte_count <= 2'd0;
            st.vec_byte   <= 1'b0;  // Start with the low vector byte
        end else begin
            st.state      <= st.state_next;
            st.microstep  <= st.microstep_next;
            st.byte_count <= st.byte_count_next;
            st.vec_byte   <= st.vec_byte_next;
        end
    end

    // Held for the whole execute phase
    always_ff @(posedge clk) begin
        if (reset) begin
            st.alu_op <= cpu_ctrl_pkg::ALU_UNDEFINED;
        end else if (st.latch_alu_op) begin
            st.alu_op <= st.alu_op_next;
        end
    end

endmodule

`default_nettype wire

/* src/sequencer_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module sequencer_fsm #(
    parameter int DATA_WIDTH = cpu_ctrl_pkg::DATA_WIDTH,
    parameter int NUM_STEPS  = cpu_ctrl_pkg::NUM_STEPS_DEFAULT
) (
    seq_state_if.logic_side                  st,
    input  wire logic [DATA_WIDTH-1:0]       flags,
    input  cpu_ctrl_pkg::control_word_t      rom_word,
    input  wire logic [1:0]                  operand_bytes,
    output cpu_ctrl_pkg::control_word_t      control_word,
    output logic                             last_microstep
);
    localparam int STEP_W = $clog2(NUM_STEPS);

    logic branch_check;  // ROM word asks for a flag test
    logic branch_taken;

    assign branch_check = rom_word.check_zero     | rom_word.check_not_zero  |
                          rom_word.check_carry    | rom_word.check_not_carry |
                          rom_word.check_negative | rom_word.check_not_negative;

    assign branch_taken =
        (rom_word.check_zero         &  flags[cpu_ctrl_pkg::FLAG_ZERO])  |
        (rom_word.check_not_zero     & ~flags[cpu_ctrl_pkg::FLAG_ZERO])  |
        (rom_word.check_carry        &  flags[cpu_ctrl_pkg::FLAG_CARRY]) |
        (rom_word.check_not_carry    & ~flags[cpu_ctrl_pkg::FLAG_CARRY]) |
        (rom_word.check_negative     &  flags[cpu_ctrl_pkg::FLAG_NEG])   |
        (rom_word.check_not_negative & ~flags[cpu_ctrl_pkg::FLAG_NEG]);

    // ============================================================
    // Next state and control word
    // ============================================================
    always_comb begin
        st.state_next      = st.state;
        st.microstep_next  = st.microstep;
        st.byte_count_next = st.byte_count;
        st.vec_byte_next   = st.vec_byte;
        st.alu_op_next     = rom_word.alu_op;
        st.latch_alu_op    = 1'b0;
        control_word       = '0;
        last_microstep     = 1'b0;

        case (st.state)
            cpu_ctrl_pkg::S_RESET: begin
                st.vec_byte_next = 1'b0;
                st.state_next    = cpu_ctrl_pkg::S_VEC_ADDR;
            end

            cpu_ctrl_pkg::S_VEC_ADDR: begin
                control_word.load_mar_vec_low  = ~st.vec_byte;
                control_word.load_mar_vec_high = st.vec_byte;
                st.state_next = cpu_ctrl_pkg::S_VEC_READ;
            end

            cpu_ctrl_pkg::S_VEC_READ: begin
                control_word.oe_ram = 1'b1;
                st.state_next = cpu_ctrl_pkg::S_VEC_LATCH;
            end

            cpu_ctrl_pkg::S_VEC_LATCH: begin
                control_word.oe_ram            = 1'b1;
                control_word.load_pc_low_byte  = ~st.vec_byte;
                control_word.load_pc_high_byte = st.vec_byte;
                st.vec_byte_next = 1'b1;
                // High byte done means PC is valid
                st.state_next = st.vec_byte ? cpu_ctrl_pkg::S_LATCH_ADDR
                                            : cpu_ctrl_pkg::S_VEC_ADDR;
            end

            cpu_ctrl_pkg::S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1;
                st.state_next = cpu_ctrl_pkg::S_READ_BYTE;
            end

            cpu_ctrl_pkg::S_READ_BYTE: begin
                control_word.oe_ram = 1'b1;
                st.state_next = cpu_ctrl_pkg::S_LATCH_BYTE;
            end

            cpu_ctrl_pkg::S_LATCH_BYTE: begin
                control_word.oe_ram      = 1'b1;
                control_word.pc_enable   = 1'b1;
                control_word.load_ir     = (st.byte_count == 2'd0);  // Opcode byte
                control_word.load_temp_1 = (st.byte_count == 2'd1);
                control_word.load_temp_2 = (st.byte_count == 2'd2);
                st.byte_count_next = st.byte_count + 2'd1;
                st.state_next      = cpu_ctrl_pkg::S_CHK_MORE_BYTES;
            end

            cpu_ctrl_pkg::S_CHK_MORE_BYTES: begin
                // Count includes the opcode byte
                if (st.byte_count > operand_bytes) begin
                    st.byte_count_next = 2'd0;
                    st.state_next      = cpu_ctrl_pkg::S_EXECUTE;
                end else begin
                    st.state_next = cpu_ctrl_pkg::S_LATCH_ADDR;
                end
            end

            cpu_ctrl_pkg::S_EXECUTE: begin
                control_word = rom_word;
                if (st.microstep == {STEP_W{1'b0}}) begin
                    st.latch_alu_op = 1'b1;
                end else begin
                    control_word.alu_op = st.alu_op;  // Hold op from step 0
                end

                if (rom_word.halt) begin
                    last_microstep    = 1'b1;
                    st.microstep_next = {STEP_W{1'b0}};
                    st.state_next     = cpu_ctrl_pkg::S_HALT;
                end else if (branch_check && !branch_taken) begin
                    // Branch not taken, PC keeps the fall-through address
                    control_word.load_pc_low_byte  = 1'b0;
                    control_word.load_pc_high_byte = 1'b0;
                    last_microstep    = 1'b1;
                    st.microstep_next = {STEP_W{1'b0}};
                    st.state_next     = cpu_ctrl_pkg::S_LATCH_ADDR;
                end else if (rom_word.last_step) begin
                    last_microstep    = 1'b1;
                    st.microstep_next = {STEP_W{1'b0}};
                    st.state_next     = cpu_ctrl_pkg::S_LATCH_ADDR;
                end else begin
                    st.microstep_next = st.microstep + STEP_W'(1);
                end
            end

            cpu_ctrl_pkg::S_HALT: begin
                st.state_next = cpu_ctrl_pkg::S_HALT;  // Only reset leaves
            end

            default: begin
                st.state_next = cpu_ctrl_pkg::S_HALT;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/microcode_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module microcode_rom #(
    parameter int NUM_STEPS = cpu_ctrl_pkg::NUM_STEPS_DEFAULT
) (
    input  cpu_ctrl_pkg::opcode_t              opcode,
    input  wire logic [$clog2(NUM_STEPS)-1:0]  microstep,
    output cpu_ctrl_pkg::control_word_t        rom_word,
    output logic [1:0]                         operand_bytes
);

    // ============================================================
    // Operand bytes per opcode
    // ============================================================
    always_comb begin
        case (opcode)
            cpu_ctrl_pkg::JMP, cpu_ctrl_pkg::JZ, cpu_ctrl_pkg::JNZ,
            cpu_ctrl_pkg::JC,  cpu_ctrl_pkg::JNC, cpu_ctrl_pkg::JN,
            cpu_ctrl_pkg::JNN, cpu_ctrl_pkg::LDA, cpu_ctrl_pkg::STA:
                operand_bytes = 2'd2;  // Address low and high
            cpu_ctrl_pkg::LDI_A, cpu_ctrl_pkg::ANI:
                operand_bytes = 2'd1;
            default:
                operand_bytes = 2'd0;  // Unknown opcodes too
        endcase
    end

    // ============================================================
    // Microcode table
    // ============================================================
    always_comb begin
        rom_word = '0;
        case (opcode)
            cpu_ctrl_pkg::JMP, cpu_ctrl_pkg::JZ, cpu_ctrl_pkg::JNZ,
            cpu_ctrl_pkg::JC,  cpu_ctrl_pkg::JNC, cpu_ctrl_pkg::JN,
            cpu_ctrl_pkg::JNN: begin
                case (microstep)
                    0: begin
                        rom_word.oe_temp_1          = 1'b1;
                        rom_word.load_pc_low_byte   = 1'b1;
                        rom_word.check_zero         = (opcode == cpu_ctrl_pkg::JZ);
                        rom_word.check_not_zero     = (opcode == cpu_ctrl_pkg::JNZ);
                        rom_word.check_carry        = (opcode == cpu_ctrl_pkg::JC);
                        rom_word.check_not_carry    = (opcode == cpu_ctrl_pkg::JNC);
                        rom_word.check_negative     = (opcode == cpu_ctrl_pkg::JN);
                        rom_word.check_not_negative = (opcode == cpu_ctrl_pkg::JNN);
                    end
                    1: begin
                        rom_word.oe_temp_2         = 1'b1;
                        rom_word.load_pc_high_byte = 1'b1;
                        rom_word.last_step         = 1'b1;
                    end
                    default: rom_word.halt = 1'b1;
                endcase
            end

            // ALU ops set the op in step 0 and write back in step 1
            cpu_ctrl_pkg::ADD_B, cpu_ctrl_pkg::SUB_B, cpu_ctrl_pkg::CMP_B,
            cpu_ctrl_pkg::INR_A, cpu_ctrl_pkg::ANI,   cpu_ctrl_pkg::RAL: begin
                case (microstep)
                    0: begin
                        case (opcode)
                            cpu_ctrl_pkg::ADD_B: rom_word.alu_op = cpu_ctrl_pkg::ALU_ADD;
                            cpu_ctrl_pkg::INR_A: rom_word.alu_op = cpu_ctrl_pkg::ALU_INR;
                            cpu_ctrl_pkg::ANI:   rom_word.alu_op = cpu_ctrl_pkg::ALU_AND;
                            cpu_ctrl_pkg::RAL:   rom_word.alu_op = cpu_ctrl_pkg::ALU_ROL;
                            default:             rom_word.alu_op = cpu_ctrl_pkg::ALU_SUB;
                        endcase
                        rom_word.oe_temp_1      = (opcode == cpu_ctrl_pkg::ANI);
                        rom_word.alu_src2_temp1 = (opcode == cpu_ctrl_pkg::ANI);
                    end
                    1: begin
                        rom_word.oe_alu      = (opcode != cpu_ctrl_pkg::CMP_B);
                        rom_word.load_a      = (opcode != cpu_ctrl_pkg::CMP_B);
                        rom_word.load_status = 1'b1;
                        rom_word.last_step   = 1'b1;
                    end
                    default: rom_word.halt = 1'b1;
                endcase
            end

            // Address from temp bytes, then RAM access
            cpu_ctrl_pkg::LDA, cpu_ctrl_pkg::STA: begin
                case (microstep)
                    0: rom_word.oe_temp_1 = 1'b1;
                    1: begin
                        rom_word.oe_temp_1         = 1'b1;
                        rom_word.load_mar_addr_low = 1'b1;
                    end
                    2: rom_word.oe_temp_2 = 1'b1;
                    3: begin
                        rom_word.oe_temp_2          = 1'b1;
                        rom_word.load_mar_addr_high = 1'b1;
                    end
                    4: begin
                        rom_word.oe_ram = (opcode == cpu_ctrl_pkg::LDA);
                        rom_word.oe_a   = (opcode == cpu_ctrl_pkg::STA);
                    end
                    5: begin
                        rom_word.oe_ram       = (opcode == cpu_ctrl_pkg::LDA);
                        rom_word.load_a       = (opcode == cpu_ctrl_pkg::LDA);
                        rom_word.load_status  = (opcode == cpu_ctrl_pkg::LDA);
                        rom_word.load_sets_zn = (opcode == cpu_ctrl_pkg::LDA);
                        rom_word.oe_a         = (opcode == cpu_ctrl_pkg::STA);
                        rom_word.load_ram     = (opcode == cpu_ctrl_pkg::STA);
                        rom_word.last_step    = 1'b1;
                    end
                    default: rom_word.halt = 1'b1;
                endcase
            end

            // Single-step instructions
            cpu_ctrl_pkg::NOP, cpu_ctrl_pkg::MOV_AB, cpu_ctrl_pkg::LDI_A,
            cpu_ctrl_pkg::SEC, cpu_ctrl_pkg::CLC: begin
                if (microstep == 0) begin
                    rom_word.oe_a             = (opcode == cpu_ctrl_pkg::MOV_AB);
                    rom_word.load_b           = (opcode == cpu_ctrl_pkg::MOV_AB);
                    rom_word.oe_temp_1        = (opcode == cpu_ctrl_pkg::LDI_A);
                    rom_word.load_a           = (opcode == cpu_ctrl_pkg::LDI_A);
                    rom_word.load_sets_zn     = (opcode == cpu_ctrl_pkg::LDI_A);
                    rom_word.set_carry_flag   = (opcode == cpu_ctrl_pkg::SEC);
                    rom_word.clear_carry_flag = (opcode == cpu_ctrl_pkg::CLC);
                    rom_word.load_status      = (opcode == cpu_ctrl_pkg::LDI_A) |
                                                (opcode == cpu_ctrl_pkg::SEC) |
                                                (opcode == cpu_ctrl_pkg::CLC);
                    rom_word.last_step        = 1'b1;
                end else begin
                    rom_word.halt = 1'b1;
                end
            end

            default: rom_word.halt = 1'b1;  // HLT and unknown opcodes
        endcase
    end

endmodule

`default_nettype wire

/* src/control_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit #(
    parameter int DATA_WIDTH = cpu_ctrl_pkg::DATA_WIDTH,
    parameter int NUM_STEPS  = cpu_ctrl_pkg::NUM_STEPS_DEFAULT
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  cpu_ctrl_pkg::opcode_t       opcode,          // From the instruction register
    input  wire logic [DATA_WIDTH-1:0]  flags,
    output cpu_ctrl_pkg::control_word_t control_word,
    output logic                        last_microstep
);

    cpu_ctrl_pkg::control_word_t rom_word;
    logic [1:0]                  operand_bytes;

    seq_state_if #(.NUM_STEPS(NUM_STEPS)) st ();

    sequencer_regs #(.NUM_STEPS(NUM_STEPS)) u_regs (
        .clk   (clk),
        .reset (reset),
        .st    (st)
    );

    sequencer_fsm #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_STEPS  (NUM_STEPS)
    ) u_fsm (
        .st             (st),
        .flags          (flags),
        .rom_word       (rom_word),
        .operand_bytes  (operand_bytes),
        .control_word   (control_word),
        .last_microstep (last_microstep)
    );

    microcode_rom #(.NUM_STEPS(NUM_STEPS)) u_rom (
        .opcode        (opcode),
        .microstep     (st.microstep),
        .rom_word      (rom_word),
        .operand_bytes (operand_bytes)
    );

endmodule

`default_nettype wire

/* dv/control_unit_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit_sva (
    input wire logic                        clk,
    input wire logic                        reset,
    input wire cpu_ctrl_pkg::control_word_t control_word,
    input wire logic                        last_microstep
);
    int         fail_count = 0;
    logic [5:0] cw_ones;  // Active bits in the control word
    logic       halted;

    assign cw_ones = 6'($countones(control_word));

    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (last_microstep && control_word.halt) begin
            halted <= 1'b1;
        end
    end

    // ============================================================
    // Reset vector, then the first fetch
    // ============================================================
    property p_reset_vector;
        @(posedge clk) $fell(reset) |->
            (cw_ones == 0)
            ##1 (control_word.load_mar_vec_low && cw_ones == 1)
            ##1 (control_word.oe_ram && cw_ones == 1)
            ##1 (control_word.oe_ram && control_word.load_pc_low_byte && cw_ones == 2)
            ##1 (control_word.load_mar_vec_high && cw_ones == 1)
            ##1 (control_word.oe_ram && cw_ones == 1)
            ##1 (control_word.oe_ram && control_word.load_pc_high_byte && cw_ones == 2)
            ##1 control_word.load_mar_pc;
    endproperty

    a_reset_vector: assert property (p_reset_vector)
        else begin
            fail_count++;
            $error("reset vector sequence did not match");
        end

    // Byte latches always advance PC and read RAM
    a_fetch_strobe: assert property (@(posedge clk) disable iff (reset)
        (control_word.load_ir || control_word.load_temp_1 || control_word.load_temp_2)
            |-> (control_word.pc_enable && control_word.oe_ram))
        else begin
            fail_count++;
            $error("fetch strobe without pc_enable and oe_ram");
        end

    a_single_last: assert property (@(posedge clk) disable iff (reset)
        last_microstep |=> !last_microstep)
        else begin
            fail_count++;
            $error("last_microstep high for more than one cycle");
        end

    a_next_fetch: assert property (@(posedge clk) disable iff (reset)
        (last_microstep && !control_word.halt) |=> control_word.load_mar_pc)
        else begin
            fail_count++;
            $error("instruction end not followed by load_mar_pc");
        end

    // Taken jump, high PC byte in the following step
    a_jump_high: assert property (@(posedge clk) disable iff (reset)
        (control_word.load_pc_low_byte && control_word.oe_temp_1)
            |=> (control_word.load_pc_high_byte && last_microstep))
        else begin
            fail_count++;
            $error("taken jump did not load the PC high byte");
        end

    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |-> (cw_ones == 0 && !last_microstep))
        else begin
            fail_count++;
            $error("control word active after halt");
        end

endmodule

`default_nettype wire

/* dv/control_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit_tb;
    localparam int PERIOD = 100;

    logic                                clk;
    logic                                reset;
    cpu_ctrl_pkg::opcode_t               opcode;
    logic [cpu_ctrl_pkg::DATA_WIDTH-1:0] flags;
    cpu_ctrl_pkg::control_word_t         control_word;
    logic                                last_microstep;

    // Program, each entry with the wanted jump outcome
    cpu_ctrl_pkg::opcode_t prog_op[$];
    bit                    prog_want[$];
    cpu_ctrl_pkg::opcode_t plain_ops[14] = '{
        cpu_ctrl_pkg::NOP,    cpu_ctrl_pkg::JMP,   cpu_ctrl_pkg::ADD_B, cpu_ctrl_pkg::SUB_B,
        cpu_ctrl_pkg::CMP_B,  cpu_ctrl_pkg::INR_A, cpu_ctrl_pkg::ANI,   cpu_ctrl_pkg::RAL,
        cpu_ctrl_pkg::MOV_AB, cpu_ctrl_pkg::LDI_A, cpu_ctrl_pkg::LDA,   cpu_ctrl_pkg::STA,
        cpu_ctrl_pkg::SEC,    cpu_ctrl_pkg::CLC};
    cpu_ctrl_pkg::opcode_t cond_ops[6] = '{
        cpu_ctrl_pkg::JZ, cpu_ctrl_pkg::JNZ, cpu_ctrl_pkg::JC,
        cpu_ctrl_pkg::JNC, cpu_ctrl_pkg::JN, cpu_ctrl_pkg::JNN};

    // Reference model
    cpu_ctrl_pkg::opcode_t cur_op;
    bit          cur_want;
    bit          fetching;
    bit          in_exec;
    bit          done;
    bit          timed_out;
    int          idx;
    int          gap;      // Cycles since the last fetched byte
    int          strobes;
    int          step;
    int          errors;
    int          sva_errors;
    int          limit;
    logic [31:0] seed;
    logic [2:0]  jump_got;
    logic [2:0]  jump_exp;

    control_unit DUT (
        .clk            (clk),
        .reset          (reset),
        .opcode         (opcode),
        .flags          (flags),
        .control_word   (control_word),
        .last_microstep (last_microstep)
    );

    bind control_unit control_unit_sva u_sva (
        .clk            (clk),
        .reset          (reset),
        .control_word   (control_word),
        .last_microstep (last_microstep)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int operand_count(input cpu_ctrl_pkg::opcode_t op);
        if (op inside {cpu_ctrl_pkg::JMP, cpu_ctrl_pkg::JZ, cpu_ctrl_pkg::JNZ,
                       cpu_ctrl_pkg::JC, cpu_ctrl_pkg::JNC, cpu_ctrl_pkg::JN,
                       cpu_ctrl_pkg::JNN, cpu_ctrl_pkg::LDA, cpu_ctrl_pkg::STA}) begin
            return 2;
        end
        return (op inside {cpu_ctrl_pkg::LDI_A, cpu_ctrl_pkg::ANI}) ? 1 : 0;
    endfunction

    function automatic cpu_ctrl_pkg::alu_op_t expected_alu(input cpu_ctrl_pkg::opcode_t op);
        case (op)
            cpu_ctrl_pkg::ADD_B: return cpu_ctrl_pkg::ALU_ADD;
            cpu_ctrl_pkg::SUB_B: return cpu_ctrl_pkg::ALU_SUB;
            cpu_ctrl_pkg::CMP_B: return cpu_ctrl_pkg::ALU_SUB;  // Compare by subtraction
            cpu_ctrl_pkg::INR_A: return cpu_ctrl_pkg::ALU_INR;
            cpu_ctrl_pkg::ANI:   return cpu_ctrl_pkg::ALU_AND;
            cpu_ctrl_pkg::RAL:   return cpu_ctrl_pkg::ALU_ROL;
            default:             return cpu_ctrl_pkg::ALU_UNDEFINED;
        endcase
    endfunction

    // Random flags with the tested condition forced
    function automatic logic [7:0] pick_flags(input logic [7:0] rnd,
                                              input cpu_ctrl_pkg::opcode_t op, input bit want);
        logic [7:0] f;
        f = rnd;
        case (op)
            cpu_ctrl_pkg::JZ:  f[cpu_ctrl_pkg::FLAG_ZERO]  = want;
            cpu_ctrl_pkg::JNZ: f[cpu_ctrl_pkg::FLAG_ZERO]  = !want;
            cpu_ctrl_pkg::JC:  f[cpu_ctrl_pkg::FLAG_CARRY] = want;
            cpu_ctrl_pkg::JNC: f[cpu_ctrl_pkg::FLAG_CARRY] = !want;
            cpu_ctrl_pkg::JN:  f[cpu_ctrl_pkg::FLAG_NEG]   = want;
            cpu_ctrl_pkg::JNN: f[cpu_ctrl_pkg::FLAG_NEG]   = !want;
            default: ;
        endcase
        return f;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ============================================================
    // Instruction register and reference checks
    // ============================================================
    always @(posedge clk) begin
        if (!reset) begin
            if (control_word.load_ir && idx < prog_op.size()) begin
                cur_op   = prog_op[idx];
                cur_want = prog_want[idx];
                opcode  <= prog_op[idx];
                idx++;
                strobes  = 0;
                gap      = 0;
                fetching = 1'b1;
                in_exec  = 1'b0;
            end else if (fetching) begin
                // Check cycle not followed by load_mar_pc, so execute starts here
                if (gap == 1 && !control_word.load_mar_pc) begin
                    assert (strobes == operand_count(cur_op)) else begin
                        errors++;
                        $display("mismatch operand strobes %s: got %h expected %h",
                                 cur_op.name(), strobes, operand_count(cur_op));
                    end
                    fetching = 1'b0;
                    in_exec  = 1'b1;
                    step     = 0;
                end else if (control_word.load_temp_1 || control_word.load_temp_2) begin
                    strobes++;
                    gap = 0;
                end else begin
                    gap++;
                end
            end
            if (in_exec) begin
                if (expected_alu(cur_op) != cpu_ctrl_pkg::ALU_UNDEFINED) begin
                    assert (control_word.alu_op == expected_alu(cur_op)) else begin
                        errors++;
                        $display("mismatch alu_op %s step %0d: got %h expected %h",
                                 cur_op.name(), step, control_word.alu_op, expected_alu(cur_op));
                    end
                end
                if (step == 0 && (cur_op == cpu_ctrl_pkg::JMP || cur_op inside {cond_ops})) begin
                    jump_got = {control_word.load_pc_low_byte, control_word.load_pc_high_byte,
                                last_microstep};
                    jump_exp = cur_want ? 3'b100 : 3'b001;
                    assert (jump_got == jump_exp) else begin
                        errors++;
                        $display("mismatch {load_pc_low_byte,load_pc_high_byte,last_microstep}"
                                 , " %s: got %h expected %h", cur_op.name(), jump_got, jump_exp);
                    end
                end
                step++;
                if (last_microstep) begin
                    in_exec = 1'b0;
                    if (cur_op == cpu_ctrl_pkg::HLT) begin
                        done = 1'b1;
                    end else if (idx < prog_op.size()) begin
                        seed   = lcg_next(seed);
                        flags <= pick_flags(seed[23:16], prog_op[idx], prog_want[idx]);
                    end
                end
            end
        end
    end

    initial begin
        reset     = 1'b1;
        opcode    = cpu_ctrl_pkg::NOP;
        seed      = 32'd39879;
        errors    = 0;
        idx       = 0;
        gap       = 0;
        fetching  = 1'b0;
        in_exec   = 1'b0;
        done      = 1'b0;
        timed_out = 1'b0;
        foreach (plain_ops[i]) begin
            prog_op.push_back(plain_ops[i]);
            prog_want.push_back(1'b1);
        end
        foreach (cond_ops[i]) begin
            prog_op.push_back(cond_ops[i]);
            prog_want.push_back(1'b1);
            prog_op.push_back(cond_ops[i]);
            prog_want.push_back(1'b0);
        end
        prog_op.push_back(cpu_ctrl_pkg::HLT);
        prog_want.push_back(1'b0);
        seed  = lcg_next(seed);
        flags = pick_flags(seed[23:16], prog_op[0], prog_want[0]);
        limit = prog_op.size() * 20 + 20;

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        fork
            wait (done);
            begin  // Watchdog
                repeat (limit) @(posedge clk);
                timed_out = 1'b1;
            end
        join_any
        repeat (4) @(posedge clk);  // Let the halt assertions run
        sva_errors = DUT.u_sva.fail_count;
        if (timed_out) begin
            $display("timeout: HLT did not complete within %0d clock cycles", limit);
        end
        $display("errors: %0d reference checks, %0d assertions", errors, sva_errors);
        if (!timed_out && errors == 0 && sva_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* control_unit.f */
src/cpu_ctrl_pkg.sv
src/seq_state_if.sv
src/sequencer_regs.sv
src/sequencer_fsm.sv
src/microcode_rom.sv
src/control_unit.sv
dv/control_unit_sva.sv
dv/control_unit_tb.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - src/cpu_ctrl_pkg.sv
  - src/seq_state_if.sv
  - src/sequencer_regs.sv
  - src/sequencer_fsm.sv
  - src/microcode_rom.sv
  - src/control_unit.sv
  - target: test
    files:
      - dv/control_unit_sva.sv
      - dv/control_unit_tb.sv
